//--- design/cmd_pkg.sv
package cmd_pkg;

    localparam int addr_bits       = 14;                     // command address width
    localparam int data_bits       = 32;                     // command data width
    localparam int addr_field_bits = 16;                     // address slot in the byte stream (AL, AH)
    localparam int cmd_bits        = data_bits + addr_field_bits; // full a/d word, 6 bytes

    // control window, host address matches ctrl_addr on the bits set in ctrl_mask
    localparam logic [addr_bits-1:0] ctrl_addr = 14'h0000;
    localparam logic [addr_bits-1:0] ctrl_mask = 14'h3800;

    localparam int len_low_bit  = 6;                         // lowest address bit of length index
    localparam int len_idx_bits = 5;                         // index into the length table
    localparam int cmd_len_bits = 3;                         // byte count 1..6

    // bytes sent per command, indexed by address bits [10:6]
    localparam logic [cmd_len_bits-1:0] cmd_len_table [32] = '{
        3'd2, 3'd4, 3'd3, 3'd3,                              // 0x000..0x0ff
        3'd6, 3'd6, 3'd4, 3'd4,                              // 0x100..0x1ff
        3'd6, 3'd6, 3'd6, 3'd6,                              // 0x200..0x2ff
        3'd6, 3'd5, 3'd6,                                    // 0x300..0x3bf
        3'd1,                                                // 0x3c0..0x3ff single-cycle class
        3'd6, 3'd6, 3'd6, 3'd6,
        3'd6, 3'd6, 3'd6, 3'd6,
        3'd6, 3'd6, 3'd6, 3'd6,
        3'd6, 3'd6, 3'd6, 3'd6
    };

    localparam int fifo_depth    = 4;                        // host write buffer entries
    localparam int fifo_ptr_bits = $clog2(fifo_depth);
    localparam int fifo_cnt_bits = $clog2(fifo_depth + 1);   // count runs 0..fifo_depth

    // source of the command being started
    typedef enum logic [1:0] {
        src_none,                                            // no start this cycle
        src_seq,                                             // frame sequencer holding register
        src_host                                             // head of the host fifo
    } cmd_src_t;

endpackage

//--- design/host_wr_fifo.sv
`timescale 1ns/1ns

module host_wr_fifo import cmd_pkg::*; (
    input  logic                 mclk,
    input  logic                 mrst,
    input  logic [addr_bits-1:0] host_waddr,   // host write address, valid with host_wr_en
    input  logic [data_bits-1:0] host_wdata,   // host write data
    input  logic                 host_wr_en,   // one write per high cycle
    input  logic                 fifo_re,      // pop head, from arbiter
    output logic                 fifo_nempty,  // head valid
    output logic [addr_bits-1:0] fifo_waddr,   // head address
    output logic [data_bits-1:0] fifo_wdata,   // head data
    output logic                 host_busy     // 2 or more entries held
);

    logic [addr_bits-1:0]     addr_mem [fifo_depth];   // address storage
    logic [data_bits-1:0]     data_mem [fifo_depth];   // data storage
    logic [fifo_ptr_bits-1:0] wr_ptr;
    logic [fifo_ptr_bits-1:0] rd_ptr;
    logic [fifo_cnt_bits-1:0] count;                   // entries currently held
    logic [fifo_cnt_bits-1:0] count_next;
    logic                     in_window;               // address inside control window
    logic                     fifo_full;
    logic                     push;
    logic                     pop;

    assign in_window = ((host_waddr ^ ctrl_addr) & ctrl_mask) == '0;
    assign fifo_full = count == fifo_cnt_bits'(fifo_depth);
    assign push      = host_wr_en && in_window && !fifo_full; // full writes are lost
    assign pop       = fifo_re && fifo_nempty;

    always_comb begin
        count_next = count;
        if (push && !pop)
            count_next = count + 1'b1;
        else if (pop && !push)
            count_next = count - 1'b1;
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            host_busy <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;               // depth is a power of two, wraps
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count     <= count_next;
            host_busy <= count_next >= fifo_cnt_bits'(2); // tracks count of this cycle
        end
    end

    always_ff @(posedge mclk) begin
        if (push) begin
            addr_mem[wr_ptr] <= host_waddr;
            data_mem[wr_ptr] <= host_wdata;
        end
    end

    // head is visible without a read cycle
    assign fifo_nempty = count != '0;
    assign fifo_waddr  = addr_mem[rd_ptr];
    assign fifo_wdata  = data_mem[rd_ptr];

endmodule

//--- design/cmd_arbiter.sv
`timescale 1ns/1ns

module cmd_arbiter import cmd_pkg::*; (
    input  logic                    mclk,
    input  logic                    mrst,
    input  logic [addr_bits-1:0]    seq_waddr,    // sequencer address, held until seq_ack
    input  logic [data_bits-1:0]    seq_wdata,    // sequencer data
    input  logic                    seq_wr_en,    // sequencer request
    output logic                    seq_ack,      // transfer cycle, combinational
    input  logic                    fifo_nempty,  // host command pending
    output logic                    fifo_re,      // pop on host start
    input  logic                    ad_stb,       // first byte cycle of loaded command
    input  logic [len_idx_bits-1:0] cmd_idx,      // length index of loaded command
    output logic                    start,        // load serializer this cycle
    output cmd_src_t                start_src,    // which source to load
    output logic [addr_bits-1:0]    seq_waddr_q,  // holding register address
    output logic [data_bits-1:0]    seq_wdata_q   // holding register data
);

    logic                    seq_full;    // holding register has a word
    logic [cmd_len_bits-1:0] cmd_len;     // bytes of the command now on the bus
    logic [cmd_len_bits-1:0] busy_cnt;    // cycles left before the next strobe may come
    logic                    can_start;   // a start now gives a strobe on time
    logic                    seq_start;
    logic                    host_start;

    assign cmd_len = cmd_len_table[cmd_idx]; // cmd_idx only meaningful with ad_stb

    // in the strobe cycle only a single-byte command lets the next one follow at once,
    // otherwise wait for the countdown to reach its last cycle
    assign can_start = ad_stb ? (cmd_len == cmd_len_bits'(1))
                              : (busy_cnt <= cmd_len_bits'(1));

    assign seq_start  = can_start && seq_full;                   // sequencer wins
    assign host_start = can_start && !seq_full && fifo_nempty;
    assign start      = seq_start || host_start;
    assign fifo_re    = host_start;

    always_comb begin
        if (seq_start)
            start_src = src_seq;
        else if (host_start)
            start_src = src_host;
        else
            start_src = src_none;
    end

    // accept a new word if empty, or if the held one leaves this cycle
    assign seq_ack = seq_wr_en && (!seq_full || seq_start);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            busy_cnt <= '0;
        end else if (ad_stb) begin
            busy_cnt <= cmd_len - 1'b1;       // len-1 after strobe, start when it hits 1
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst)
            seq_full <= 1'b0;
        else
            seq_full <= seq_ack || (seq_full && !seq_start);
    end

    always_ff @(posedge mclk) begin
        if (seq_ack) begin
            seq_waddr_q <= seq_waddr;         // capture on transfer
            seq_wdata_q <= seq_wdata;
        end
    end

endmodule

//--- design/cmd_serializer.sv
`timescale 1ns/1ns

module cmd_serializer import cmd_pkg::*; (
    input  logic                    mclk,
    input  logic                    mrst,
    input  logic                    start,        // load a new command
    input  cmd_src_t                start_src,    // source of the load
    input  logic [addr_bits-1:0]    seq_waddr_q,  // sequencer holding register
    input  logic [data_bits-1:0]    seq_wdata_q,
    input  logic [addr_bits-1:0]    fifo_waddr,   // host fifo head
    input  logic [data_bits-1:0]    fifo_wdata,
    output logic                    ad_stb,       // AL cycle, parallel view valid
    output logic [len_idx_bits-1:0] cmd_idx,      // length index of loaded command
    output logic [addr_bits-1:0]    par_waddr,    // parallel address
    output logic [data_bits-1:0]    par_data,     // parallel data
    output logic [7:0]              byte_ad       // AL, AH, D0..D3 one per cycle
);

    logic [cmd_bits-1:0] par_ad;                  // {data, pad, addr}, low byte goes out first

    always_ff @(posedge mclk) begin
        if (mrst) begin
            par_ad <= '0;
            ad_stb <= 1'b0;
        end else begin
            ad_stb <= start;                      // strobe one cycle after start
            if (start) begin
                case (start_src)
                    src_seq:  par_ad <= {seq_wdata_q, {(addr_field_bits-addr_bits){1'b0}},
                                         seq_waddr_q};
                    src_host: par_ad <= {fifo_wdata, {(addr_field_bits-addr_bits){1'b0}},
                                         fifo_waddr};
                    default:  par_ad <= '0;
                endcase
            end else begin
                par_ad <= {8'h00, par_ad[cmd_bits-1:8]}; // next byte down, zeros fill in
            end
        end
    end

    assign cmd_idx   = par_ad[len_low_bit +: len_idx_bits];
    assign par_waddr = par_ad[addr_bits-1:0];
    assign par_data  = par_ad[cmd_bits-1 -: data_bits];
    assign byte_ad   = par_ad[7:0];

endmodule

//--- design/cmd_mux_top.sv
`timescale 1ns/1ns

module cmd_mux_top import cmd_pkg::*; (
    input  logic                 mclk,
    input  logic                 mrst,
    // host writes
    input  logic [addr_bits-1:0] host_waddr,
    input  logic [data_bits-1:0] host_wdata,
    input  logic                 host_wr_en,
    output logic                 host_busy,   // stop writing while high
    // frame sequencer writes
    input  logic [addr_bits-1:0] seq_waddr,
    input  logic [data_bits-1:0] seq_wdata,
    input  logic                 seq_wr_en,
    output logic                 seq_ack,     // word taken this cycle
    // merged command stream
    output logic [addr_bits-1:0] par_waddr,
    output logic [data_bits-1:0] par_data,
    output logic [7:0]           byte_ad,
    output logic                 ad_stb
);

    logic                    fifo_nempty;
    logic [addr_bits-1:0]    fifo_waddr;      // fifo head
    logic [data_bits-1:0]    fifo_wdata;
    logic                    fifo_re;
    logic                    start;
    cmd_src_t                start_src;
    logic [addr_bits-1:0]    seq_waddr_q;     // holding register
    logic [data_bits-1:0]    seq_wdata_q;
    logic [len_idx_bits-1:0] cmd_idx;

    host_wr_fifo host_wr_fifo_i (
        .mclk        (mclk),
        .mrst        (mrst),
        .host_waddr  (host_waddr),
        .host_wdata  (host_wdata),
        .host_wr_en  (host_wr_en),
        .fifo_re     (fifo_re),
        .fifo_nempty (fifo_nempty),
        .fifo_waddr  (fifo_waddr),
        .fifo_wdata  (fifo_wdata),
        .host_busy   (host_busy)
    );

    cmd_arbiter cmd_arbiter_i (
        .mclk        (mclk),
        .mrst        (mrst),
        .seq_waddr   (seq_waddr),
        .seq_wdata   (seq_wdata),
        .seq_wr_en   (seq_wr_en),
        .seq_ack     (seq_ack),
        .fifo_nempty (fifo_nempty),
        .fifo_re     (fifo_re),
        .ad_stb      (ad_stb),
        .cmd_idx     (cmd_idx),
        .start       (start),
        .start_src   (start_src),
        .seq_waddr_q (seq_waddr_q),
        .seq_wdata_q (seq_wdata_q)
    );

    cmd_serializer cmd_serializer_i (
        .mclk        (mclk),
        .mrst        (mrst),
        .start       (start),
        .start_src   (start_src),
        .seq_waddr_q (seq_waddr_q),
        .seq_wdata_q (seq_wdata_q),
        .fifo_waddr  (fifo_waddr),
        .fifo_wdata  (fifo_wdata),
        .ad_stb      (ad_stb),
        .cmd_idx     (cmd_idx),
        .par_waddr   (par_waddr),
        .par_data    (par_data),
        .byte_ad     (byte_ad)
    );

endmodule

//--- test/cmd_mux_model.svh
`ifndef CMD_MUX_MODEL_SVH
`define CMD_MUX_MODEL_SVH

logic [addr_bits+data_bits-1:0] host_q [$];          // accepted host writes {addr, data}, oldest first
logic                           seq_held   = 1'b0;   // sequencer word taken, not yet started
logic [addr_bits-1:0]           seq_addr_m = '0;
logic [data_bits-1:0]           seq_data_m = '0;
logic                           strobe_due = 1'b0;   // started last cycle, strobe expected now
logic [addr_bits-1:0]           next_addr  = '0;     // command that strobes next
logic [data_bits-1:0]           next_data  = '0;
logic [addr_bits-1:0]           cur_addr   = '0;     // command now on the byte bus
logic [data_bits-1:0]           cur_data   = '0;
int                             cur_len    = 1;
int                             since_stb  = 100;    // cycles since last strobe, saturates

// byte count of a command, from address bits 10..6
function automatic int cmd_len(input logic [addr_bits-1:0] addr);
    return int'(cmd_len_table[addr[len_low_bit +: 5]]);
endfunction

function automatic bit addr_in_window(input logic [addr_bits-1:0] addr);
    return (addr & ctrl_mask) == (ctrl_addr & ctrl_mask); // match on masked bits only
endfunction

// byte k of the stream: AL, AH, then data low byte first
function automatic logic [7:0] stream_byte(input logic [addr_bits-1:0] addr,
                                           input logic [data_bits-1:0] data, input int k);
    case (k)
        0:       return addr[7:0];
        1:       return {2'b00, addr[13:8]};                  // AH padded to 16 address bits
        default: return data[(k-2)*8 +: 8];
    endcase
endfunction

// start rule, a held sequencer word goes before any host entry
task automatic pick_next(input bit free, output bit seq_start);
    seq_start  = free && seq_held;
    strobe_due = 1'b0;
    if (seq_start) begin
        next_addr  = seq_addr_m;
        next_data  = seq_data_m;
        strobe_due = 1'b1;
    end else if (free && host_q.size() != 0) begin
        {next_addr, next_data} = host_q.pop_front();
        strobe_due = 1'b1;
    end
endtask

function automatic bit model_idle();
    return !seq_held && host_q.size() == 0 && !strobe_due;
endfunction

`endif

//--- test/cmd_mux_tb.sv
`timescale 1ns/1ns

module cmd_mux_tb import cmd_pkg::*; ();

    localparam int clk_period = 40;
    localparam int num_cmds   = 1500;     // stimulus cycles, each may carry a new command

    logic                 mclk       = 1'b0;
    logic                 mrst       = 1'b1;
    logic [addr_bits-1:0] host_waddr = '0;
    logic [data_bits-1:0] host_wdata = '0;
    logic                 host_wr_en = 1'b0;
    logic                 host_busy;
    logic [addr_bits-1:0] seq_waddr  = '0;
    logic [data_bits-1:0] seq_wdata  = '0;
    logic                 seq_wr_en  = 1'b0;
    logic                 seq_ack;
    logic [addr_bits-1:0] par_waddr;
    logic [data_bits-1:0] par_data;
    logic [7:0]           byte_ad;
    logic                 ad_stb;

    integer seed        = 77;
    int     n_value_err = 0;
    int     n_other_err = 0;
    int     n_accepted  = 0;              // sequencer acks plus in-window host writes
    int     n_strobes   = 0;              // strobes seen on the dut output
    bit     seq_taken   = 1'b0;           // request went through in the last cycle

    `include "cmd_mux_model.svh"

    cmd_mux_top cmd_mux_top_i (
        .mclk       (mclk),
        .mrst       (mrst),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .host_wr_en (host_wr_en),
        .host_busy  (host_busy),
        .seq_waddr  (seq_waddr),
        .seq_wdata  (seq_wdata),
        .seq_wr_en  (seq_wr_en),
        .seq_ack    (seq_ack),
        .par_waddr  (par_waddr),
        .par_data   (par_data),
        .byte_ad    (byte_ad),
        .ad_stb     (ad_stb)
    );

    always #(clk_period/2) mclk = ~mclk;

    // where: 0 any, 1 inside the window, 2 outside it
    function automatic logic [addr_bits-1:0] random_addr(input int where);
        logic [addr_bits-1:0] a;
        a = $random(seed);
        if (($random(seed) & 3) == 0)
            a[len_low_bit +: 5] = 5'd15;                        // single-byte class now and then
        if (where == 1)
            a = (a & ~ctrl_mask) | (ctrl_addr & ctrl_mask);
        else if (where == 2)
            while (addr_in_window(a))
                a = a ^ (ctrl_mask & addr_bits'($random(seed)));
        return a;
    endfunction

    task automatic check_value(input string name, input logic [47:0] got, input logic [47:0] exp);
        assert (got === exp) else begin
            $display("Fail %s at %0t: got %h expected %h", name, $time, got, exp);
            n_value_err++;
        end
    endtask

    task automatic drive_inputs(input bit new_work);
        if (!seq_wr_en || seq_taken) begin                      // hold a word until it is taken
            seq_wr_en = new_work && (($random(seed) & 7) == 0);
            seq_waddr = random_addr(0);
            seq_wdata = $random(seed);
        end
        host_wr_en = new_work && !host_busy && (($random(seed) & 3) == 0);
        host_waddr = random_addr((($random(seed) & 3) == 0) ? 2 : 1); // about a quarter outside
        host_wdata = $random(seed);
    endtask

    // one cycle of the model, outputs sampled after the falling-edge drive
    task automatic step_model();
        bit free;
        bit seq_start;
        bit exp_ack;
        if (since_stb < 100)
            since_stb++;
        check_value("ad_stb", ad_stb, strobe_due);
        if (ad_stb === 1'b1) begin                              // spacing seen on the dut strobe
            assert (since_stb >= cur_len) else begin
                $display("strobe at %0t came only %0d cycles after the last one", $time, since_stb);
                n_other_err++;
            end
            n_strobes++;
        end
        if (strobe_due) begin
            cur_addr  = next_addr;
            cur_data  = next_data;
            cur_len   = cmd_len(next_addr);
            since_stb = 0;
            check_value("par_waddr", par_waddr, cur_addr);
            check_value("par_data", par_data, cur_data);
        end
        if (since_stb < cur_len)
            check_value("byte_ad", byte_ad, stream_byte(cur_addr, cur_data, since_stb));
        else if (since_stb >= 6)
            check_value("byte_ad", byte_ad, 8'h00);             // stream drained
        check_value("host_busy", host_busy, host_q.size() >= 2);
        free = since_stb >= cur_len - 1;                        // next strobe lands len after this one
        pick_next(free, seq_start);
        exp_ack = seq_wr_en && (!seq_held || seq_start);
        check_value("seq_ack", seq_ack, exp_ack);
        seq_held  = exp_ack || (seq_held && !seq_start);
        seq_taken = exp_ack;
        if (exp_ack) begin
            seq_addr_m = seq_waddr;
            seq_data_m = seq_wdata;
            n_accepted++;
        end
        if (host_wr_en && addr_in_window(host_waddr)) begin
            host_q.push_back({host_waddr, host_wdata});
            n_accepted++;
        end
    endtask

    initial begin
        #((num_cmds * 10 + 200) * clk_period);
        $display("watchdog expired before the command stream drained");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        repeat (10) begin
            @(negedge mclk);
            assert (ad_stb === 1'b0 && host_busy === 1'b0 && seq_ack === 1'b0) else begin
                $display("outputs not idle during reset at %0t", $time);
                n_other_err++;
            end
        end
        mrst = 1'b0;
        @(negedge mclk);                                        // first cycle out of reset, inputs idle
        #1;
        step_model();
        repeat (num_cmds) begin
            @(negedge mclk);
            drive_inputs(1'b1);
            #1;
            step_model();
        end
        while (seq_wr_en || !model_idle()) begin                // no new work, drain what is held
            @(negedge mclk);
            drive_inputs(1'b0);
            #1;
            step_model();
        end
        repeat (8) begin
            @(negedge mclk);
            #1;
            step_model();
        end
        assert (n_accepted == n_strobes) else begin
            $display("%0d commands were accepted but %0d were strobed", n_accepted, n_strobes);
            n_other_err++;
        end
        $display("%0d commands checked, %0d value errors, %0d other errors",
                 n_strobes, n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- cmd_mux_top.f
+incdir+test
design/cmd_pkg.sv
design/host_wr_fifo.sv
design/cmd_arbiter.sv
design/cmd_serializer.sv
design/cmd_mux_top.sv
test/cmd_mux_tb.sv

//--- Bender.yml
package:
  name: cmd_mux

sources:
  - design/cmd_pkg.sv
  - design/host_wr_fifo.sv
  - design/cmd_arbiter.sv
  - design/cmd_serializer.sv
  - design/cmd_mux_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cmd_mux_tb.sv
